/* pipe_types_pkg.sv */
`default_nettype none

package pipe_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction field widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 32 architectural registers
    localparam int unsigned REG_IDX_W = 5;

    // one tag per issued pair
    localparam int unsigned TAG_W = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // architectural register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // instruction pair tag
    typedef logic [TAG_W-1:0] tag_t;

    // hardwired zero register, never a real producer
    localparam reg_idx_t REG_ZERO = '0;

endpackage : pipe_types_pkg

`default_nettype wire

/* pipe_ctrl_pkg.sv */
`default_nettype none

package pipe_ctrl_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline boundary registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // ii/id2, id2/ex, ex/mem and mem/wb
    localparam int unsigned NUM_BOUNDARIES = 4;

    // one bit per boundary register
    typedef logic [NUM_BOUNDARIES-1:0] stage_mask_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bit positions inside stage_mask_t
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // front of the pipe, fed from the issue point
    localparam int unsigned B_II_ID2 = 0;

    localparam int unsigned B_ID2_EX = 1;

    localparam int unsigned B_EX_MEM = 2;

    // last boundary, retires from here
    localparam int unsigned B_MEM_WB = 3;

endpackage : pipe_ctrl_pkg

`default_nettype wire

/* lane_hazard.sv */
`default_nettype none
`timescale 1ns/10ps

module lane_hazard
    import pipe_types_pkg::*;
#(
    parameter bit ZERO_REG_FIXED = 1'b1
) (
    // pair currently in id2, sources of this lane
    input  wire      id2_valid,
    input  wire      reg_idx_t src_a,
    input  wire      reg_idx_t src_b,

    // pair currently in ex, load info of both lanes
    input  wire      ex_valid,
    input  wire      ex_c_load,
    input  wire      reg_idx_t ex_c_dest,
    input  wire      ex_p_load,
    input  wire      reg_idx_t ex_p_dest,

    output logic     stall_req
);

    logic c_dest_live;
    logic p_dest_live;
    logic c_match;
    logic p_match;
    logic c_hit;
    logic p_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // producer qualification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // r0 writes are discarded when the zero register is hardwired
    assign c_dest_live = !ZERO_REG_FIXED || (ex_c_dest != REG_ZERO);
    assign p_dest_live = !ZERO_REG_FIXED || (ex_p_dest != REG_ZERO);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // source compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign c_match = (src_a == ex_c_dest) || (src_b == ex_c_dest);
    assign p_match = (src_a == ex_p_dest) || (src_b == ex_p_dest);

    // load data is not ready until mem, so no forward path covers it
    assign c_hit = ex_c_load && c_dest_live && c_match;
    assign p_hit = ex_p_load && p_dest_live && p_match;

    assign stall_req = id2_valid && ex_valid && (c_hit || p_hit);

endmodule : lane_hazard

`default_nettype wire

/* pipe_ctrl.sv */
`default_nettype none
`timescale 1ns/10ps

module pipe_ctrl
    import pipe_ctrl_pkg::*;
(
    // external requests
    input  wire  i_cache_stall_req,
    input  wire  d_cache_stall_req,
    input  wire  fifo_stall_req,
    input  wire  b_ctrl_flush_req,
    input  wire  exc_stall_req,
    input  wire  exp_stall_req,
    input  wire  exc_tlb_stall_req,
    input  wire  exp_tlb_stall_req,
    input  wire  exception_flush,
    input  wire  mem_refetch,

    // load-use requests from the two hazard units
    input  wire  forwardc_stall_req,
    input  wire  forwardp_stall_req,

    output logic        pc_stall,
    output logic        fifo_flush,
    output logic        issue_stall,
    output stage_mask_t stall_mask,
    output stage_mask_t flush_mask
);

    logic exc;
    logic fwd;
    logic exc_stall_any;
    logic tlb_stall_any;
    logic lsu;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request groups
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // redirect from the back end
    assign exc           = exception_flush | mem_refetch;
    assign fwd           = forwardc_stall_req | forwardp_stall_req;
    assign exc_stall_any = exc_stall_req | exp_stall_req;
    assign tlb_stall_any = exc_tlb_stall_req | exp_tlb_stall_req;
    assign lsu           = d_cache_stall_req | exc_stall_any | tlb_stall_any;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // front end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pc_stall    = i_cache_stall_req | fifo_stall_req;
    // a branch resolved behind a load-use bubble is replayed, keep the fifo
    assign fifo_flush  = (b_ctrl_flush_req & ~fwd) | exc;
    assign issue_stall = lsu | fwd;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per boundary controls
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        stall_mask = '0;
        flush_mask = '0;

        stall_mask[B_II_ID2] = issue_stall | (pc_stall & fifo_flush);
        flush_mask[B_II_ID2] = b_ctrl_flush_req | exc;

        // a load-use hazard leaves a bubble behind the load
        stall_mask[B_ID2_EX] = lsu;
        flush_mask[B_ID2_EX] = b_ctrl_flush_req | fwd | exc;

        // tlb miss squashes the faulting pair
        stall_mask[B_EX_MEM] = d_cache_stall_req | exc_stall_any;
        flush_mask[B_EX_MEM] = exc | tlb_stall_any;

        // mem/wb is never flushed, older pair always completes
        stall_mask[B_MEM_WB] = d_cache_stall_req | (exc_stall_any & ~exc);
    end

endmodule : pipe_ctrl

`default_nettype wire

/* stage_chain.sv */
`default_nettype none
`timescale 1ns/10ps

module stage_chain
    import pipe_types_pkg::*;
    import pipe_ctrl_pkg::*;
(
    input  wire  clk,
    input  wire  arst_n,

    // pair offered at the issue point
    input  wire  issue_valid,
    input  wire  tag_t     issue_tag,
    input  wire  reg_idx_t issue_c_src_a,
    input  wire  reg_idx_t issue_c_src_b,
    input  wire  reg_idx_t issue_c_dest,
    input  wire  issue_c_load,
    input  wire  reg_idx_t issue_p_src_a,
    input  wire  reg_idx_t issue_p_src_b,
    input  wire  reg_idx_t issue_p_dest,
    input  wire  issue_p_load,

    input  wire  stage_mask_t stall_mask,
    input  wire  stage_mask_t flush_mask,

    // id2 stage, read by the hazard units
    output logic     id2_valid,
    output reg_idx_t id2_c_src_a,
    output reg_idx_t id2_c_src_b,
    output reg_idx_t id2_p_src_a,
    output reg_idx_t id2_p_src_b,

    // ex stage load info
    output logic     ex_valid,
    output logic     ex_c_load,
    output reg_idx_t ex_c_dest,
    output logic     ex_p_load,
    output reg_idx_t ex_p_dest,

    output logic     retire_valid,
    output tag_t     retire_tag
);

    stage_mask_t valid_q;
    stage_mask_t valid_in;
    stage_mask_t valid_d;

    tag_t        id2_tag_q;
    reg_idx_t    id2_c_dest_q;
    logic        id2_c_load_q;
    reg_idx_t    id2_p_dest_q;
    logic        id2_p_load_q;
    tag_t        ex_tag_q;
    tag_t        mem_tag_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // valid chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // what each boundary would take when it advances
    assign valid_in = {valid_q[B_EX_MEM], valid_q[B_ID2_EX], valid_q[B_II_ID2], issue_valid};

    // flush beats stall beats advance
    always_comb begin
        for (int b = 0; b < NUM_BOUNDARIES; b++) begin
            if (flush_mask[b]) begin
                valid_d[b] = 1'b0;
            end else if (stall_mask[b]) begin
                valid_d[b] = valid_q[b];
            end else begin
                valid_d[b] = valid_in[b];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // contents behind a cleared valid are don't care
    always_ff @(posedge clk) begin
        if (!stall_mask[B_II_ID2]) begin
            id2_tag_q    <= issue_tag;
            id2_c_src_a  <= issue_c_src_a;
            id2_c_src_b  <= issue_c_src_b;
            id2_c_dest_q <= issue_c_dest;
            id2_c_load_q <= issue_c_load;
            id2_p_src_a  <= issue_p_src_a;
            id2_p_src_b  <= issue_p_src_b;
            id2_p_dest_q <= issue_p_dest;
            id2_p_load_q <= issue_p_load;
        end
        // sources are consumed in id2
        if (!stall_mask[B_ID2_EX]) begin
            ex_tag_q  <= id2_tag_q;
            ex_c_dest <= id2_c_dest_q;
            ex_c_load <= id2_c_load_q;
            ex_p_dest <= id2_p_dest_q;
            ex_p_load <= id2_p_load_q;
        end
        if (!stall_mask[B_EX_MEM]) begin
            mem_tag_q <= ex_tag_q;
        end
        if (!stall_mask[B_MEM_WB]) begin
            retire_tag <= mem_tag_q;
        end
    end

    assign id2_valid = valid_q[B_II_ID2];
    assign ex_valid  = valid_q[B_ID2_EX];

    // a held pair retires on the cycle its stall drops
    assign retire_valid = valid_q[B_MEM_WB] & ~stall_mask[B_MEM_WB];

endmodule : stage_chain

`default_nettype wire

/* pipe_ctrl_top.sv */
`default_nettype none
`timescale 1ns/10ps

module pipe_ctrl_top
    import pipe_types_pkg::*;
    import pipe_ctrl_pkg::*;
#(
    parameter bit ZERO_REG_FIXED = 1'b1
) (
    input  wire  clk,
    input  wire  arst_n,

    input  wire  issue_valid,
    input  wire  tag_t     issue_tag,
    input  wire  reg_idx_t issue_c_src_a,
    input  wire  reg_idx_t issue_c_src_b,
    input  wire  reg_idx_t issue_c_dest,
    input  wire  issue_c_load,
    input  wire  reg_idx_t issue_p_src_a,
    input  wire  reg_idx_t issue_p_src_b,
    input  wire  reg_idx_t issue_p_dest,
    input  wire  issue_p_load,

    input  wire  i_cache_stall_req,
    input  wire  d_cache_stall_req,
    input  wire  fifo_stall_req,
    input  wire  b_ctrl_flush_req,
    input  wire  exc_stall_req,
    input  wire  exp_stall_req,
    input  wire  exc_tlb_stall_req,
    input  wire  exp_tlb_stall_req,
    input  wire  exception_flush,
    input  wire  mem_refetch,

    output logic pc_stall,
    output logic fifo_flush,
    output logic issue_stall,
    output logic retire_valid,
    output tag_t retire_tag
);

    logic        id2_valid;
    reg_idx_t    id2_c_src_a;
    reg_idx_t    id2_c_src_b;
    reg_idx_t    id2_p_src_a;
    reg_idx_t    id2_p_src_b;
    logic        ex_valid;
    logic        ex_c_load;
    reg_idx_t    ex_c_dest;
    logic        ex_p_load;
    reg_idx_t    ex_p_dest;
    logic        forwardc_stall_req;
    logic        forwardp_stall_req;
    stage_mask_t stall_mask;
    stage_mask_t flush_mask;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // load-use detection, one unit per lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    lane_hazard #(.ZERO_REG_FIXED(ZERO_REG_FIXED)) hazard_c_i (
        .id2_valid (id2_valid),
        .src_a     (id2_c_src_a),
        .src_b     (id2_c_src_b),
        .ex_valid  (ex_valid),
        .ex_c_load (ex_c_load),
        .ex_c_dest (ex_c_dest),
        .ex_p_load (ex_p_load),
        .ex_p_dest (ex_p_dest),
        .stall_req (forwardc_stall_req)
    );

    lane_hazard #(.ZERO_REG_FIXED(ZERO_REG_FIXED)) hazard_p_i (
        .id2_valid (id2_valid),
        .src_a     (id2_p_src_a),
        .src_b     (id2_p_src_b),
        .ex_valid  (ex_valid),
        .ex_c_load (ex_c_load),
        .ex_c_dest (ex_c_dest),
        .ex_p_load (ex_p_load),
        .ex_p_dest (ex_p_dest),
        .stall_req (forwardp_stall_req)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stall and flush control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    pipe_ctrl pipe_ctrl_i (
        .i_cache_stall_req  (i_cache_stall_req),
        .d_cache_stall_req  (d_cache_stall_req),
        .fifo_stall_req     (fifo_stall_req),
        .b_ctrl_flush_req   (b_ctrl_flush_req),
        .exc_stall_req      (exc_stall_req),
        .exp_stall_req      (exp_stall_req),
        .exc_tlb_stall_req  (exc_tlb_stall_req),
        .exp_tlb_stall_req  (exp_tlb_stall_req),
        .exception_flush    (exception_flush),
        .mem_refetch        (mem_refetch),
        .forwardc_stall_req (forwardc_stall_req),
        .forwardp_stall_req (forwardp_stall_req),
        .pc_stall           (pc_stall),
        .fifo_flush         (fifo_flush),
        .issue_stall        (issue_stall),
        .stall_mask         (stall_mask),
        .flush_mask         (flush_mask)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // boundary registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    stage_chain stage_chain_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .issue_valid   (issue_valid),
        .issue_tag     (issue_tag),
        .issue_c_src_a (issue_c_src_a),
        .issue_c_src_b (issue_c_src_b),
        .issue_c_dest  (issue_c_dest),
        .issue_c_load  (issue_c_load),
        .issue_p_src_a (issue_p_src_a),
        .issue_p_src_b (issue_p_src_b),
        .issue_p_dest  (issue_p_dest),
        .issue_p_load  (issue_p_load),
        .stall_mask    (stall_mask),
        .flush_mask    (flush_mask),
        .id2_valid     (id2_valid),
        .id2_c_src_a   (id2_c_src_a),
        .id2_c_src_b   (id2_c_src_b),
        .id2_p_src_a   (id2_p_src_a),
        .id2_p_src_b   (id2_p_src_b),
        .ex_valid      (ex_valid),
        .ex_c_load     (ex_c_load),
        .ex_c_dest     (ex_c_dest),
        .ex_p_load     (ex_p_load),
        .ex_p_dest     (ex_p_dest),
        .retire_valid  (retire_valid),
        .retire_tag    (retire_tag)
    );

endmodule : pipe_ctrl_top

`default_nettype wire

/* tb_pipe_model.svh */
`ifndef TB_PIPE_MODEL_SVH
`define TB_PIPE_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// model state, one valid and tag per boundary
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

stage_mask_t mdl_valid;
tag_t        mdl_tag [4];
reg_idx_t    mdl_id2_src [4];
reg_idx_t    mdl_id2_c_dest;
reg_idx_t    mdl_id2_p_dest;
logic        mdl_id2_c_load;
logic        mdl_id2_p_load;
reg_idx_t    mdl_ex_c_dest;
reg_idx_t    mdl_ex_p_dest;
logic        mdl_ex_c_load;
logic        mdl_ex_p_load;

// expected controls for the current cycle
logic        exp_pc_stall;
logic        exp_fifo_flush;
logic        exp_issue_stall;
logic        exp_retire_valid;
stage_mask_t exp_stall;
stage_mask_t exp_flush;

// r0 never produces, so a load to r0 is no hazard
function automatic logic load_use_hit(input reg_idx_t a, input reg_idx_t b);
    logic c_hit;
    logic p_hit;
    c_hit = mdl_ex_c_load && (mdl_ex_c_dest != 5'd0)
        && (a == mdl_ex_c_dest || b == mdl_ex_c_dest);
    p_hit = mdl_ex_p_load && (mdl_ex_p_dest != 5'd0)
        && (a == mdl_ex_p_dest || b == mdl_ex_p_dest);
    return mdl_valid[0] && mdl_valid[1] && (c_hit || p_hit);
endfunction

task automatic eval_controls();
    logic exc;
    logic fwd;
    logic lsu;
    logic exc_st;
    logic tlb_st;
    exc    = exception_flush | mem_refetch;
    fwd    = load_use_hit(mdl_id2_src[0], mdl_id2_src[1])
        | load_use_hit(mdl_id2_src[2], mdl_id2_src[3]);
    exc_st = exc_stall_req | exp_stall_req;
    tlb_st = exc_tlb_stall_req | exp_tlb_stall_req;
    lsu    = d_cache_stall_req | exc_st | tlb_st;

    exp_pc_stall    = i_cache_stall_req | fifo_stall_req;
    exp_fifo_flush  = (b_ctrl_flush_req & !fwd) | exc;
    exp_issue_stall = lsu | fwd;

    exp_stall[0] = exp_issue_stall | (exp_pc_stall & exp_fifo_flush);
    exp_flush[0] = b_ctrl_flush_req | exc;
    exp_stall[1] = lsu;
    exp_flush[1] = b_ctrl_flush_req | fwd | exc;
    exp_stall[2] = d_cache_stall_req | exc_st;
    exp_flush[2] = exc | tlb_st;
    exp_stall[3] = d_cache_stall_req | (exc_st & !exc);
    exp_flush[3] = 1'b0;

    exp_retire_valid = mdl_valid[3] & !exp_stall[3];
endtask

task automatic clear_chain();
    mdl_valid = '0;
endtask

`endif

/* tb_pipe_ctrl_top.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_pipe_ctrl_top
    import pipe_types_pkg::*;
    import pipe_ctrl_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    localparam int REQ_PCT      = 6;

    // test lengths in cycles
    localparam int FREE_FLOW_CYCLES = 200;
    localparam int LOAD_USE_CYCLES  = 300;
    localparam int BRANCH_CYCLES    = 300;
    localparam int EXCEPTION_CYCLES = 300;
    localparam int LSU_CYCLES       = 400;
    localparam int FRONT_END_CYCLES = 300;
    localparam int MIXED_CYCLES     = 600;
    localparam int TOTAL_CYCLES     = FREE_FLOW_CYCLES + LOAD_USE_CYCLES + BRANCH_CYCLES
                                    + EXCEPTION_CYCLES + LSU_CYCLES + FRONT_END_CYCLES
                                    + MIXED_CYCLES;
    localparam int MARGIN_CYCLES    = 200;

    logic     clk;
    logic     arst_n;
    logic     issue_valid;
    tag_t     issue_tag;
    reg_idx_t issue_c_src_a;
    reg_idx_t issue_c_src_b;
    reg_idx_t issue_c_dest;
    logic     issue_c_load;
    reg_idx_t issue_p_src_a;
    reg_idx_t issue_p_src_b;
    reg_idx_t issue_p_dest;
    logic     issue_p_load;
    logic     i_cache_stall_req;
    logic     d_cache_stall_req;
    logic     fifo_stall_req;
    logic     b_ctrl_flush_req;
    logic     exc_stall_req;
    logic     exp_stall_req;
    logic     exc_tlb_stall_req;
    logic     exp_tlb_stall_req;
    logic     exception_flush;
    logic     mem_refetch;
    logic     pc_stall;
    logic     fifo_flush;
    logic     issue_stall;
    logic     retire_valid;
    tag_t     retire_tag;

    tag_t     next_tag;
    logic     hold_pair;
    int       retire_count;
    int       hazard_count;

    `include "tb_pipe_model.svh"

    pipe_ctrl_top pipe_ctrl_top_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s expected %0b actual %0b", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_tag(input string name, input tag_t exp, input tag_t act);
        if (act !== exp) begin
            $display("Fail %s expected %0h actual %0h", name, exp, act);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and model step
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic pick(input logic [9:0] en, input int idx);
        return en[idx] && ($urandom_range(0, 99) < REQ_PCT);
    endfunction

    task automatic drive_inputs(input logic [9:0] en, input bit loads);
        // a pair held back by issue_stall stays on the inputs
        if (!hold_pair) begin
            issue_valid   = ($urandom_range(0, 9) < 8);
            issue_tag     = next_tag;
            issue_c_src_a = reg_idx_t'($urandom_range(0, 3));
            issue_c_src_b = reg_idx_t'($urandom_range(0, 3));
            issue_c_dest  = reg_idx_t'($urandom_range(0, 3));
            issue_c_load  = loads && $urandom_range(0, 1);
            issue_p_src_a = reg_idx_t'($urandom_range(0, 3));
            issue_p_src_b = reg_idx_t'($urandom_range(0, 3));
            issue_p_dest  = reg_idx_t'($urandom_range(0, 3));
            issue_p_load  = loads && $urandom_range(0, 1);
            if (issue_valid) begin
                next_tag = next_tag + 8'd1;
            end
        end
        i_cache_stall_req = pick(en, 0);
        d_cache_stall_req = pick(en, 1);
        fifo_stall_req    = pick(en, 2);
        b_ctrl_flush_req  = pick(en, 3);
        exc_stall_req     = pick(en, 4);
        exp_stall_req     = pick(en, 5);
        exc_tlb_stall_req = pick(en, 6);
        exp_tlb_stall_req = pick(en, 7);
        exception_flush   = pick(en, 8);
        mem_refetch       = pick(en, 9);
    endtask

    // flush beats stall beats advance
    // oldest boundary first
    task automatic advance_chain();
        for (int b = 3; b >= 0; b--) begin
            if (!exp_stall[b]) begin
                mdl_tag[b] = (b == 0) ? issue_tag : mdl_tag[b-1];
            end
            if (exp_flush[b]) begin
                mdl_valid[b] = 1'b0;
            end else if (!exp_stall[b]) begin
                mdl_valid[b] = (b == 0) ? issue_valid : mdl_valid[b-1];
            end
        end
        if (!exp_stall[1]) begin
            mdl_ex_c_dest = mdl_id2_c_dest;
            mdl_ex_p_dest = mdl_id2_p_dest;
            mdl_ex_c_load = mdl_id2_c_load;
            mdl_ex_p_load = mdl_id2_p_load;
        end
        if (!exp_stall[0]) begin
            mdl_id2_src[0] = issue_c_src_a;
            mdl_id2_src[1] = issue_c_src_b;
            mdl_id2_src[2] = issue_p_src_a;
            mdl_id2_src[3] = issue_p_src_b;
            mdl_id2_c_dest = issue_c_dest;
            mdl_id2_p_dest = issue_p_dest;
            mdl_id2_c_load = issue_c_load;
            mdl_id2_p_load = issue_p_load;
        end
    endtask

    task automatic run_phase(input string name, input int cycles, input logic [9:0] en,
                             input bit loads);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            drive_inputs(en, loads);
            #1;
            eval_controls();
            check_bit({name, " pc_stall"}, exp_pc_stall, pc_stall);
            check_bit({name, " fifo_flush"}, exp_fifo_flush, fifo_flush);
            check_bit({name, " issue_stall"}, exp_issue_stall, issue_stall);
            check_bit({name, " retire_valid"}, exp_retire_valid, retire_valid);
            if (exp_retire_valid) begin
                check_tag({name, " retire_tag"}, mdl_tag[3], retire_tag);
                retire_count++;
            end
            if (exp_issue_stall && !exp_stall[1]) begin
                hazard_count++;
            end
            hold_pair = issue_valid && exp_stall[0] && !exp_flush[0];
            @(posedge clk);
            advance_chain();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        void'($urandom(32'h8e90));
        clk          = 1'b0;
        arst_n       = 1'b0;
        next_tag     = '0;
        hold_pair    = 1'b0;
        retire_count = 0;
        hazard_count = 0;
        issue_valid  = 1'b0;
        issue_tag    = '0;
        issue_c_src_a = '0;
        issue_c_src_b = '0;
        issue_c_dest  = '0;
        issue_c_load  = 1'b0;
        issue_p_src_a = '0;
        issue_p_src_b = '0;
        issue_p_dest  = '0;
        issue_p_load  = 1'b0;
        drive_inputs(10'h000, 1'b0);
        issue_valid = 1'b0;
        clear_chain();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_bit("reset retire_valid", 1'b0, retire_valid);

        run_phase("free_flow", FREE_FLOW_CYCLES, 10'h000, 1'b0);
        if (retire_count == 0) begin
            $display("no pair retired during free flow");
            $display("** FAIL **");
            $fatal(1);
        end
        run_phase("load_use", LOAD_USE_CYCLES, 10'h000, 1'b1);
        if (hazard_count == 0) begin
            $display("no load-use stall was seen during the load-use test");
            $display("** FAIL **");
            $fatal(1);
        end
        run_phase("branch_flush", BRANCH_CYCLES, 10'h008, 1'b1);
        run_phase("exception", EXCEPTION_CYCLES, 10'h300, 1'b1);
        run_phase("lsu_stalls", LSU_CYCLES, 10'h0f2, 1'b1);
        run_phase("front_end", FRONT_END_CYCLES, 10'h00d, 1'b1);
        run_phase("mixed", MIXED_CYCLES, 10'h3ff, 1'b1);
        $display("** PASS **");
        $finish;
    end

    // limit from the summed test length plus margin
    initial begin
        #((RESET_CYCLES + TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("the run hung and did not finish in time");
        $display("** FAIL **");
        $fatal(1);
    end

endmodule : tb_pipe_ctrl_top

`default_nettype wire

/* pipe_ctrl_top.f */
+incdir+.
pipe_types_pkg.sv
pipe_ctrl_pkg.sv
lane_hazard.sv
pipe_ctrl.sv
stage_chain.sv
pipe_ctrl_top.sv
tb_pipe_ctrl_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f pipe_ctrl_top.f \
    --top-module tb_pipe_ctrl_top -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
